// File: Bender.yml
package:
  name: aim_predictor

sources:
  - bp_kind_pkg.sv
  - bp_meta_pkg.sv
  - local_history_table.sv
  - tagged_history_table.sv
  - choice_table.sv
  - aim_predictor.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - aim_predictor_properties.sv
      - aim_predictor_tb.sv

// File: aim_predictor.sv
`timescale 1ns/100ps

module aim_predictor
    import bp_kind_pkg::*;
    import bp_meta_pkg::*;
#(
    parameter int h_width    = 8,
    parameter int bh_width   = 16,
    parameter int gh_width   = 32,
    parameter int addr_width = 30
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  stall,
    input  logic                  update_en,
    // execute stage feedback
    input  logic [addr_width-1:0] pc_ex,
    input  logic [bh_width-1:0]   bh_ex,
    input  logic [gh_width-1:0]   gh_ex,
    input  logic [2:0]            kind_ex,
    input  ctr_t                  choice_pdch_ex,
    input  logic                  taken_real,
    input  ctr_t                  taken_pdch_ex_b,
    input  ctr_t                  taken_pdch_ex_g,
    input  bp_meta_t              tage_pdch_ex,
    input  logic                  taken_pdc_ex,
    // prediction
    input  logic [2:0]            kind_pdc,
    output logic                  taken_pdc,
    output logic                  choice_b_g,
    output ctr_t                  choice_pdch,
    output ctr_t                  taken_pdch_b,
    output ctr_t                  taken_pdch_g,
    output bp_meta_t              tage_pdch,
    // current request
    input  logic [gh_width-1:0]   gh,
    input  logic [addr_width-1:0] pc,
    input  logic [bh_width-1:0]   bh_reg,
    input  logic [addr_width-1:0] pc_reg
);

    logic         taken_b;
    logic         taken_g;
    logic         upd;
    branch_kind_t kind_p;

    // only conditional branches train the tables
    assign upd = update_en && (kind_ex == direct_jump);

    local_history_table #(
        .h_width(h_width),
        .bh_width(bh_width),
        .addr_width(addr_width)
    ) u_local (
        .clk(clk),
        .rst_n(rst_n),
        .stall(stall),
        .pc(pc_reg),
        .bh(bh_reg),
        .update_en(upd),
        .pc_update(pc_ex),
        .bh_update(bh_ex),
        .taken_real(taken_real),
        .taken_pdch_ex_b(taken_pdch_ex_b),
        .b_taken_pdc(taken_b),
        .taken_pdch_b(taken_pdch_b)
    );

    tagged_history_table #(
        .h_width(h_width),
        .gh_width(gh_width),
        .addr_width(addr_width)
    ) u_tagged (
        .clk(clk),
        .rst_n(rst_n),
        .stall(stall),
        .pc(pc),
        .gh(gh),
        .taken_bh(taken_b),
        .update_en(upd),
        .pc_ex(pc_ex),
        .gh_ex(gh_ex),
        .taken_pdc_ex(taken_pdc_ex),
        .taken_ex(taken_real),
        .pdch_ex(tage_pdch_ex),
        .taken_pdc(taken_g),
        .pdch(tage_pdch)
    );

    choice_table #(
        .h_width(h_width),
        .addr_width(addr_width)
    ) u_choice (
        .clk(clk),
        .rst_n(rst_n),
        .stall(stall),
        .pc(pc_reg),
        .update_en(upd),
        .pc_update(pc_ex),
        .taken_real(taken_real),
        .taken_b_ex(taken_pdch_ex_b[1]),
        .taken_g_ex(taken_pdch_ex_g[1]),
        .choice_pdch_ex(choice_pdch_ex),
        .choice_b_g(choice_b_g),
        .choice_pdch(choice_pdch)
    );

    // global side has no counter of its own to return
    assign taken_pdch_g = {taken_g, 1'b0};

    assign kind_p = branch_kind_t'(kind_pdc);

    always_comb begin
        case (kind_p)
            direct_jump:                  taken_pdc = choice_b_g ? taken_g : taken_b;
            ret, indirect_jump, call, jump: taken_pdc = 1'b1;
            default:                      taken_pdc = 1'b0;
        endcase
    end

endmodule

// File: aim_predictor_properties.sv
`timescale 1ns/100ps

module aim_predictor_properties
    import bp_kind_pkg::*;
    import bp_meta_pkg::*;
(
    input logic       clk,
    input logic       rst_n,
    input logic       stall,
    input logic [2:0] kind_pdc,
    input logic       taken_pdc,
    input logic       choice_b_g,
    input ctr_t       choice_pdch,
    input ctr_t       taken_pdch_b,
    input ctr_t       taken_pdch_g,
    input bp_meta_t   tage_pdch
);

    int fail_count = 0;

    // unconditional kinds never predict not taken
    unconditional_taken: assert property (
        @(posedge clk) disable iff (!rst_n) kind_pdc[2] |-> taken_pdc
    ) else begin
        fail_count++;
        $error("unconditional kind predicted not taken");
    end

    // a stalled edge freezes every table output
    stall_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        stall |=> $stable({choice_b_g, choice_pdch, taken_pdch_b, taken_pdch_g, tage_pdch})
    ) else begin
        fail_count++;
        $error("predictor outputs changed across a stalled clock");
    end

    miss_spare_zero: assert property (
        @(posedge clk) disable iff (!rst_n)
        !tage_pdch.miss_v.hit |-> tage_pdch.miss_v.spare == 2'b00
    ) else begin
        fail_count++;
        $error("spare bits of the miss view are not zero");
    end

endmodule

// File: aim_predictor_tb.sv
`timescale 1ns/100ps

module aim_predictor_tb
    import bp_kind_pkg::*;
    import bp_meta_pkg::*;
();

    localparam int depth = 256;

    typedef struct packed {
        ctr_t       b_ctr;
        ctr_t       ch_ctr;
        logic       hit;
        ctr_t       t_ctr;
        logic [7:0] tag;
    } exp_t;

    logic        clk, rst_n, stall, update_en, taken_real, taken_pdc_ex;
    logic        taken_pdc, choice_b_g;
    logic [2:0]  kind_ex, kind_pdc;
    logic [29:0] pc, pc_reg, pc_ex;
    logic [15:0] bh_reg, bh_ex;
    logic [31:0] gh, gh_ex;
    ctr_t        choice_pdch_ex, taken_pdch_ex_b, taken_pdch_ex_g;
    ctr_t        choice_pdch, taken_pdch_b, taken_pdch_g;
    bp_meta_t    tage_pdch_ex, tage_pdch;

    // reference copies of the three tables
    ctr_t       loc_ctr [depth];
    ctr_t       tag_ctr [depth];
    ctr_t       sel_ctr [depth];
    logic       tag_valid [depth];
    logic [7:0] tag_val [depth];

    exp_t       exp_q;
    logic       have_exp = 1'b0;
    int         err_count = 0;
    int         n;
    logic [2:0] kinds [8] = '{3'd0, 3'd1, 3'd1, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};

    tb_clock_gen clock_i (
        .clk(clk),
        .rst_n(rst_n)
    );

    aim_predictor #(
        .h_width(8),
        .bh_width(16),
        .gh_width(32),
        .addr_width(30)
    ) aim_predictor_i (.*);

    bind aim_predictor aim_predictor_properties props_i (.*);

    function automatic ctr_t sat_step(input ctr_t c, input logic up);
        if (up) begin
            return (c == 2'd3) ? c : c + 2'd1;
        end
        return (c == 2'd0) ? c : c - 2'd1;
    endfunction

    // reference model of one request against the current tables
    function automatic exp_t ref_predict(input logic [29:0] p_reg, input logic [15:0] b,
                                         input logic [29:0] p, input logic [31:0] g);
        exp_t       e;
        logic [7:0] ti;
        ti       = p[7:0] ^ g[7:0] ^ g[15:8] ^ g[23:16] ^ g[31:24];
        e.b_ctr  = loc_ctr[p_reg[7:0] ^ b[7:0]];
        e.ch_ctr = sel_ctr[p_reg[7:0]];
        e.tag    = p[15:8] ^ g[31:24];
        e.hit    = tag_valid[ti] && (tag_val[ti] == e.tag);
        e.t_ctr  = tag_ctr[ti];
        return e;
    endfunction

    function automatic logic ref_global(input exp_t e);
        return e.hit ? e.t_ctr[1] : e.b_ctr[1];
    endfunction

    function automatic logic ref_taken(input logic [2:0] k, input exp_t e);
        if (k[2]) begin
            return 1'b1;
        end
        if (k == 3'd1) begin
            return e.ch_ctr[1] ? ref_global(e) : e.b_ctr[1];
        end
        return 1'b0;
    endfunction

    function automatic logic [11:0] ref_meta(input exp_t e);
        if (e.hit) begin
            return {1'b1, e.t_ctr, e.tag, e.b_ctr[1]};
        end
        return {1'b0, e.tag, e.b_ctr[1], 2'b00};
    endfunction

    task automatic model_update();
        logic [7:0] ti;
        ti = pc_ex[7:0] ^ gh_ex[7:0] ^ gh_ex[15:8] ^ gh_ex[23:16] ^ gh_ex[31:24];
        loc_ctr[pc_ex[7:0] ^ bh_ex[7:0]] = sat_step(taken_pdch_ex_b, taken_real);
        if (tage_pdch_ex[11]) begin
            tag_ctr[ti] = sat_step(tage_pdch_ex[10:9], taken_real);
        end else if (taken_pdc_ex != taken_real) begin
            tag_valid[ti] = 1'b1;
            tag_val[ti]   = tage_pdch_ex[10:3];
            tag_ctr[ti]   = taken_real ? 2'd2 : 2'd1;
        end
        // chooser only learns from a disagreement
        if (taken_pdch_ex_b[1] != taken_pdch_ex_g[1]) begin
            sel_ctr[pc_ex[7:0]] = sat_step(choice_pdch_ex, taken_pdch_ex_g[1] == taken_real);
        end
    endtask

    task automatic check_val(input string what, input logic [11:0] got, input logic [11:0] want);
        assert (got === want) else begin
            err_count++;
            $display("Error at %0t ns: %s is %0h, expected %0h", $time, what, got, want);
        end
    endtask

    task automatic request(input logic [29:0] a, input logic [15:0] b, input logic [31:0] g,
                           input logic [2:0] k);
        @(negedge clk);
        pc        = a;
        pc_reg    = a;
        bh_reg    = b;
        gh        = g;
        kind_pdc  = k;
        stall     = 1'b0;
        update_en = 1'b0;
        @(posedge clk);
        #30;
    endtask

    // execute stage feedback of the last request and its snapshot
    task automatic update(input logic [2:0] k, input logic outcome, input logic en,
                          input logic st);
        @(negedge clk);
        stall           = st;
        update_en       = en;
        kind_ex         = k;
        pc_ex           = pc_reg;
        bh_ex           = bh_reg;
        gh_ex           = gh;
        choice_pdch_ex  = choice_pdch;
        taken_pdch_ex_b = taken_pdch_b;
        taken_pdch_ex_g = taken_pdch_g;
        tage_pdch_ex    = tage_pdch;
        taken_pdc_ex    = taken_pdc;
        taken_real      = outcome;
        @(posedge clk);
    endtask

    // the prediction reads old table values before a write on the same edge
    initial begin
        forever begin
            @(posedge clk);
            if (!rst_n) begin
                for (int i = 0; i < depth; i++) begin
                    loc_ctr[i]   = 2'd1;
                    tag_ctr[i]   = 2'd1;
                    sel_ctr[i]   = 2'd1;
                    tag_valid[i] = 1'b0;
                    tag_val[i]   = 8'd0;
                end
                have_exp = 1'b0;
            end else if (!stall) begin
                exp_q    = ref_predict(pc_reg, bh_reg, pc, gh);
                have_exp = 1'b1;
                if (update_en && kind_ex == 3'd1) begin
                    model_update();
                end
            end
            #25;
            if (have_exp) begin
                check_val("taken_pdc", taken_pdc, ref_taken(kind_pdc, exp_q));
                check_val("choice_b_g", choice_b_g, exp_q.ch_ctr[1]);
                check_val("choice_pdch", choice_pdch, exp_q.ch_ctr);
                check_val("taken_pdch_b", taken_pdch_b, exp_q.b_ctr);
                check_val("taken_pdch_g", taken_pdch_g, {ref_global(exp_q), 1'b0});
                check_val("tage_pdch", tage_pdch, ref_meta(exp_q));
            end
        end
    end

    initial begin
        void'($urandom(32'h7163));
        {stall, update_en, taken_real, taken_pdc_ex, kind_ex, kind_pdc} = '0;
        {pc, pc_reg, pc_ex, gh, gh_ex, bh_reg, bh_ex} = '0;
        {choice_pdch_ex, taken_pdch_ex_b, taken_pdch_ex_g, tage_pdch_ex} = '0;
        n = 0;
        while (rst_n !== 1'b1 && n < 20) begin
            @(posedge clk);
            n++;
        end
        if (rst_n !== 1'b1) begin
            $display("reset was not released within 20 clocks");
            $display("TEST FAILED");
            $finish;
        end
        for (int i = 0; i < 4; i++) begin
            request($urandom, $urandom, $urandom, 3'd1);
            check_val("fresh local counter", taken_pdch_b, 12'd1);
            check_val("fresh tagged hit", tage_pdch.hit_v.hit, 12'd0);
        end
        foreach (kinds[i]) begin
            request($urandom, $urandom, $urandom, kinds[i]);
            check_val("taken for kind", taken_pdc, kinds[i][2]);
        end
        // local counter walks up to saturation and back down
        request(30'h123, 16'h0, 32'h0, 3'd1);
        for (int i = 0; i < 4; i++) begin
            update(3'd1, 1'b1, 1'b1, 1'b0);
            request(30'h123, 16'h0, 32'h0, 3'd1);
            check_val("local counter up", taken_pdch_b, (i < 2) ? i + 2 : 3);
        end
        for (int i = 0; i < 4; i++) begin
            update(3'd1, 1'b0, 1'b1, 1'b0);
            request(30'h123, 16'h0, 32'h0, 3'd1);
            check_val("local counter down", taken_pdch_b, (i < 3) ? 2 - i : 0);
        end
        // a mispredicted miss allocates with tag pc[15:8] ^ gh[31:24]
        request(30'h4a0, 16'h0, 32'h5500_00f0, 3'd1);
        update(3'd1, 1'b1, 1'b1, 1'b0);
        request(30'h4a0, 16'h0, 32'h5500_00f0, 3'd1);
        check_val("allocated hit", tage_pdch.hit_v.hit, 12'd1);
        check_val("stored tag", tage_pdch.hit_v.tag, 12'h51);
        // same tagged index under another tag
        request(30'h4a0, 16'h0, 32'h3300_66f0, 3'd1);
        check_val("other history hit", tage_pdch.hit_v.hit, 12'd0);
        // fresh local entry says not taken while the tagged entry says taken
        request(30'h4a0, 16'h0011, 32'h5500_00f0, 3'd1);
        check_val("side predictions", {taken_pdch_b[1], taken_pdch_g[1]}, 12'b01);
        update(3'd5, 1'b1, 1'b1, 1'b0);
        update(3'd1, 1'b1, 1'b0, 1'b0);
        update(3'd1, 1'b1, 1'b1, 1'b1);
        request(30'h4a0, 16'h0011, 32'h5500_00f0, 3'd1);
        check_val("chooser untouched", choice_pdch, 12'd1);
        update(3'd1, 1'b1, 1'b1, 1'b0);
        request(30'h4a0, 16'h0011, 32'h5500_00f0, 3'd1);
        check_val("chooser picks global", choice_b_g, 12'd1);
        check_val("tagged counter trained", tage_pdch.hit_v.ctr, 12'd3);
        for (int i = 0; i < 400; i++) begin
            if ($urandom % 3 != 0) begin
                request($urandom & 30'h0fff, $urandom & 16'h7, $urandom & 32'h0300_0003,
                        kinds[$urandom % 8]);
            end else begin
                update(kinds[$urandom % 8], $urandom, $urandom % 4 != 0, $urandom % 8 == 0);
            end
        end
        @(negedge clk);
        n = err_count + aim_predictor_i.props_i.fail_count;
        $display("%0d value errors, %0d assertion failures", err_count,
                 aim_predictor_i.props_i.fail_count);
        if (n == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: bp_kind_pkg.sv
package bp_kind_pkg;

    // bit 2 marks the unconditional kinds
    typedef enum logic [2:0] {
        not_jump      = 3'd0,
        direct_jump   = 3'd1,
        ret           = 3'd4,
        indirect_jump = 3'd5,
        call          = 3'd6,
        jump          = 3'd7
    } branch_kind_t;

    localparam int ctr_width = 2;

    typedef logic [ctr_width-1:0] ctr_t;

    localparam ctr_t ctr_min        = 2'd0;
    localparam ctr_t ctr_reset_val  = 2'd1;
    localparam ctr_t ctr_weak_taken = 2'd2;
    localparam ctr_t ctr_max        = 2'd3;

    function automatic logic ctr_taken(input ctr_t c);
        return c[ctr_width-1];
    endfunction

    // saturating step toward the real outcome
    function automatic ctr_t ctr_train(input ctr_t c, input logic taken);
        if (taken) begin
            return (c == ctr_max) ? ctr_max : c + ctr_t'(1);
        end
        return (c == ctr_min) ? ctr_min : c - ctr_t'(1);
    endfunction

endpackage

// File: bp_meta_pkg.sv
package bp_meta_pkg;

    import bp_kind_pkg::*;

    localparam int tag_width = 8;

    // entry matched, counter and tag come from the table
    typedef struct packed {
        logic                 hit;
        ctr_t                 ctr;
        logic [tag_width-1:0] tag;
        logic                 alt_taken;
    } meta_hit_t;

    // no match, keep what allocation needs
    typedef struct packed {
        logic                 hit;
        logic [tag_width-1:0] tag;
        logic                 base_taken;
        logic [1:0]           spare;
    } meta_miss_t;

    // pdch word, the top bit tells which view applies
    typedef union packed {
        meta_hit_t  hit_v;
        meta_miss_t miss_v;
    } bp_meta_t;

endpackage

// File: choice_table.sv
`timescale 1ns/100ps

module choice_table
    import bp_kind_pkg::*;
#(
    parameter int h_width    = 8,
    parameter int addr_width = 30
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  stall,
    input  logic [addr_width-1:0] pc,
    input  logic                  update_en,
    input  logic [addr_width-1:0] pc_update,
    input  logic                  taken_real,
    input  logic                  taken_b_ex,
    input  logic                  taken_g_ex,
    input  ctr_t                  choice_pdch_ex,
    output logic                  choice_b_g,
    output ctr_t                  choice_pdch
);

    localparam int depth = 1 << h_width;

    ctr_t ctr_mem [depth];
    ctr_t rd_q;
    logic wr_en;

    // nothing to learn when both sides agreed
    assign wr_en = update_en && !stall && (taken_b_ex != taken_g_ex);

    // count up when the global side was right
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < depth; i++) begin
                ctr_mem[i] <= ctr_reset_val;
            end
        end else if (wr_en) begin
            ctr_mem[pc_update[h_width-1:0]] <=
                ctr_train(choice_pdch_ex, taken_g_ex == taken_real);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_q <= '0;
        end else if (!stall) begin
            rd_q <= ctr_mem[pc[h_width-1:0]];
        end
    end

    // 0 picks local, 1 picks global
    assign choice_b_g  = ctr_taken(rd_q);
    assign choice_pdch = rd_q;

endmodule

// File: filelist.f
bp_kind_pkg.sv
bp_meta_pkg.sv
local_history_table.sv
tagged_history_table.sv
choice_table.sv
aim_predictor.sv
tb_clock_gen.sv
aim_predictor_properties.sv
aim_predictor_tb.sv

// File: local_history_table.sv
`timescale 1ns/100ps

module local_history_table
    import bp_kind_pkg::*;
#(
    parameter int h_width    = 8,
    parameter int bh_width   = 16,
    parameter int addr_width = 30
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  stall,
    input  logic [addr_width-1:0] pc,
    input  logic [bh_width-1:0]   bh,
    input  logic                  update_en,
    input  logic [addr_width-1:0] pc_update,
    input  logic [bh_width-1:0]   bh_update,
    input  logic                  taken_real,
    input  ctr_t                  taken_pdch_ex_b,
    output logic                  b_taken_pdc,
    output ctr_t                  taken_pdch_b
);

    localparam int depth = 1 << h_width;

    ctr_t ctr_mem [depth];
    ctr_t rd_q;

    logic [h_width-1:0] rd_idx;
    logic [h_width-1:0] wr_idx;
    logic               wr_en;

    // pc hashed with the branch's own history
    assign rd_idx = pc[h_width-1:0] ^ bh[h_width-1:0];
    assign wr_idx = pc_update[h_width-1:0] ^ bh_update[h_width-1:0];

    assign wr_en = update_en && !stall;

    // snapshot counter is trained, so the table is never read back
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < depth; i++) begin
                ctr_mem[i] <= ctr_reset_val;
            end
        end else if (wr_en) begin
            ctr_mem[wr_idx] <= ctr_train(taken_pdch_ex_b, taken_real);
        end
    end

    // read register holds while stalled
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_q <= '0;
        end else if (!stall) begin
            rd_q <= ctr_mem[rd_idx];
        end
    end

    assign taken_pdch_b = rd_q;
    assign b_taken_pdc  = ctr_taken(rd_q);

endmodule

// File: tagged_history_table.sv
`timescale 1ns/100ps

module tagged_history_table
    import bp_kind_pkg::*;
    import bp_meta_pkg::*;
#(
    parameter int h_width    = 8,
    parameter int gh_width   = 32,
    parameter int addr_width = 30
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  stall,
    input  logic [addr_width-1:0] pc,
    input  logic [gh_width-1:0]   gh,
    input  logic                  taken_bh,
    input  logic                  update_en,
    input  logic [addr_width-1:0] pc_ex,
    input  logic [gh_width-1:0]   gh_ex,
    input  logic                  taken_pdc_ex,
    input  logic                  taken_ex,
    input  bp_meta_t              pdch_ex,
    output logic                  taken_pdc,
    output bp_meta_t              pdch
);

    localparam int depth = 1 << h_width;

    logic                 valid_mem [depth];
    ctr_t                 ctr_mem   [depth];
    logic [tag_width-1:0] tag_mem   [depth];

    logic [h_width-1:0]   rd_idx;
    logic [h_width-1:0]   wr_idx;
    logic [tag_width-1:0] rd_tag;
    logic                 rd_hit;

    logic                 hit_q;
    ctr_t                 ctr_q;
    logic [tag_width-1:0] tag_q;

    logic                 wr_en;
    logic                 alloc;

    // xor-fold of the global history down to index width
    function automatic logic [h_width-1:0] fold_gh(input logic [gh_width-1:0] g);
        logic [h_width-1:0] acc;
        acc = '0;
        for (int i = 0; i < gh_width; i++) begin
            acc[i % h_width] ^= g[i];
        end
        return acc;
    endfunction

    assign rd_idx = pc[h_width-1:0] ^ fold_gh(gh);
    assign wr_idx = pc_ex[h_width-1:0] ^ fold_gh(gh_ex);

    // tag from the pc bits just above the index
    assign rd_tag = pc[h_width +: tag_width] ^ gh[gh_width-1 -: tag_width];
    assign rd_hit = valid_mem[rd_idx] && (tag_mem[rd_idx] == rd_tag);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hit_q <= 1'b0;
            ctr_q <= '0;
            tag_q <= '0;
        end else if (!stall) begin
            hit_q <= rd_hit;
            ctr_q <= ctr_mem[rd_idx];
            tag_q <= rd_tag;
        end
    end

    assign wr_en = update_en && !stall;

    // only a wrong guess on a miss earns an entry
    assign alloc = !pdch_ex.miss_v.hit && (taken_pdc_ex != taken_ex);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < depth; i++) begin
                valid_mem[i] <= 1'b0;
                ctr_mem[i]   <= ctr_reset_val;
            end
        end else if (wr_en) begin
            if (pdch_ex.hit_v.hit) begin
                ctr_mem[wr_idx] <= ctr_train(pdch_ex.hit_v.ctr, taken_ex);
            end else if (alloc) begin
                valid_mem[wr_idx] <= 1'b1;
                ctr_mem[wr_idx]   <= taken_ex ? ctr_weak_taken : ctr_reset_val;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en && alloc) begin
            tag_mem[wr_idx] <= pdch_ex.miss_v.tag;
        end
    end

    // miss falls back to the local guess
    assign taken_pdc = hit_q ? ctr_taken(ctr_q) : taken_bh;

    always_comb begin
        pdch = '0;
        if (hit_q) begin
            pdch.hit_v.hit       = 1'b1;
            pdch.hit_v.ctr       = ctr_q;
            pdch.hit_v.tag       = tag_q;
            pdch.hit_v.alt_taken = taken_bh;
        end else begin
            pdch.miss_v.hit        = 1'b0;
            pdch.miss_v.tag        = tag_q;
            pdch.miss_v.base_taken = taken_bh;
            pdch.miss_v.spare      = 2'b00;
        end
    end

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // reset spans three rising edges, released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule
